//--- source/adder_pkg.sv
package adder_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Full operand and result width
	localparam int DATA_WIDTH = 32;

	// One prefix tree covers half of the word
	localparam int HALF_WIDTH = DATA_WIDTH / 2;

	// log2 of HALF_WIDTH
	localparam int HALF_LEVELS = 4;

	////////////////////////////////////////////////////////////////////////////
	// Word types
	////////////////////////////////////////////////////////////////////////////

	// Operand and result word
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Operand slice and prefix terms of one tree
	typedef logic [HALF_WIDTH-1:0] half_t;

endpackage

//--- source/sklansky_half_tree.sv
`timescale 1ns/1ns

module sklansky_half_tree (
	input  adder_pkg::half_t a_i,
	input  adder_pkg::half_t b_i,
	output adder_pkg::half_t bit_p_o,
	output adder_pkg::half_t group_g_o,
	output adder_pkg::half_t group_p_o
);

	////////////////////////////////////////////////////////////////////////////
	// Prefix terms per level
	////////////////////////////////////////////////////////////////////////////

	// Entry 0 holds the bit terms, entry k+1 the terms after level k
	wire adder_pkg::half_t g_lvl [adder_pkg::HALF_LEVELS+1];
	wire adder_pkg::half_t p_lvl [adder_pkg::HALF_LEVELS+1];

	// Bit generate and propagate
	assign g_lvl[0] = a_i & b_i;
	assign p_lvl[0] = a_i ^ b_i;

	////////////////////////////////////////////////////////////////////////////
	// Sklansky levels
	////////////////////////////////////////////////////////////////////////////

	for (genvar k = 0; k < adder_pkg::HALF_LEVELS; k++) begin : g_level
		for (genvar i = 0; i < adder_pkg::HALF_WIDTH; i++) begin : g_bit
			if (((i >> k) & 1) == 1) begin : g_combine
				// Top bit of the lower part of this block
				localparam int J = ((i >> (k + 1)) << (k + 1)) + (1 << k) - 1;

				assign g_lvl[k+1][i] = g_lvl[k][i] | (p_lvl[k][i] & g_lvl[k][J]);
				assign p_lvl[k+1][i] = p_lvl[k][i] & p_lvl[k][J];
			end else begin : g_pass
				// Lower part already spans down to the block start
				assign g_lvl[k+1][i] = g_lvl[k][i];
				assign p_lvl[k+1][i] = p_lvl[k][i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// Bit propagate is kept for the sum XOR
	assign bit_p_o = p_lvl[0];

	// Spans from each bit down to bit 0 of this tree
	assign group_g_o = g_lvl[adder_pkg::HALF_LEVELS];
	assign group_p_o = p_lvl[adder_pkg::HALF_LEVELS];

endmodule

//--- source/carry_merge_sum.sv
`timescale 1ns/1ns

module carry_merge_sum (
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              carry_in_i,
	input  adder_pkg::half_t  low_bit_p_i,
	input  adder_pkg::half_t  low_group_g_i,
	input  adder_pkg::half_t  low_group_p_i,
	input  adder_pkg::half_t  high_bit_p_i,
	input  adder_pkg::half_t  high_group_g_i,
	input  adder_pkg::half_t  high_group_p_i,
	output adder_pkg::data_t  sum_o,
	output logic              overflow_o
);

	adder_pkg::half_t low_carry_out;
	adder_pkg::half_t high_carry_out;
	logic             mid_carry;
	adder_pkg::data_t carry_into;
	adder_pkg::data_t sum_d;
	logic             overflow_d;

	////////////////////////////////////////////////////////////////////////////
	// Carry merge
	////////////////////////////////////////////////////////////////////////////

	// Carry-in acts as a generate below bit 0
	assign low_carry_out = low_group_g_i
		| (low_group_p_i & {adder_pkg::HALF_WIDTH{carry_in_i}});

	// Carry out of bit 15 feeds the upper tree
	assign mid_carry = low_carry_out[adder_pkg::HALF_WIDTH-1];

	assign high_carry_out = high_group_g_i
		| (high_group_p_i & {adder_pkg::HALF_WIDTH{mid_carry}});

	// Carry into each bit, shifted up by one position
	assign carry_into = {
		high_carry_out[adder_pkg::HALF_WIDTH-2:0],
		mid_carry,
		low_carry_out[adder_pkg::HALF_WIDTH-2:0],
		carry_in_i
	};

	////////////////////////////////////////////////////////////////////////////
	// Sum and overflow
	////////////////////////////////////////////////////////////////////////////

	assign sum_d = {high_bit_p_i, low_bit_p_i} ^ carry_into;

	// Signed overflow from carries around the sign bit
	assign overflow_d = carry_into[adder_pkg::DATA_WIDTH-1]
		^ high_carry_out[adder_pkg::HALF_WIDTH-1];

	// Result register
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			sum_o      <= '0;
			overflow_o <= 1'b0;
		end else begin
			sum_o      <= sum_d;
			overflow_o <= overflow_d;
		end
	end

endmodule

//--- source/sklansky_add_sub.sv
`timescale 1ns/1ns

module sklansky_add_sub (
	input  logic             clk_i,
	input  logic             reset_i,
	input  adder_pkg::data_t a_i,
	input  adder_pkg::data_t b_i,
	input  logic             sub_i,
	output adder_pkg::data_t sum_o,
	output logic             overflow_o
);

	adder_pkg::data_t b_eff;

	adder_pkg::half_t low_bit_p;
	adder_pkg::half_t low_group_g;
	adder_pkg::half_t low_group_p;
	adder_pkg::half_t high_bit_p;
	adder_pkg::half_t high_group_g;
	adder_pkg::half_t high_group_p;

	// Invert B for subtraction, the +1 comes in as carry-in
	assign b_eff = b_i ^ {adder_pkg::DATA_WIDTH{sub_i}};

	////////////////////////////////////////////////////////////////////////////
	// Prefix trees, bits 15..0 and 31..16
	////////////////////////////////////////////////////////////////////////////

	sklansky_half_tree i_low_tree (
		.a_i       (a_i[adder_pkg::HALF_WIDTH-1:0]),
		.b_i       (b_eff[adder_pkg::HALF_WIDTH-1:0]),
		.bit_p_o   (low_bit_p),
		.group_g_o (low_group_g),
		.group_p_o (low_group_p)
	);

	sklansky_half_tree i_high_tree (
		.a_i       (a_i[adder_pkg::DATA_WIDTH-1:adder_pkg::HALF_WIDTH]),
		.b_i       (b_eff[adder_pkg::DATA_WIDTH-1:adder_pkg::HALF_WIDTH]),
		.bit_p_o   (high_bit_p),
		.group_g_o (high_group_g),
		.group_p_o (high_group_p)
	);

	////////////////////////////////////////////////////////////////////////////
	// Merge and output register
	////////////////////////////////////////////////////////////////////////////

	carry_merge_sum i_merge (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.carry_in_i     (sub_i),
		.low_bit_p_i    (low_bit_p),
		.low_group_g_i  (low_group_g),
		.low_group_p_i  (low_group_p),
		.high_bit_p_i   (high_bit_p),
		.high_group_g_i (high_group_g),
		.high_group_p_i (high_group_p),
		.sum_o          (sum_o),
		.overflow_o     (overflow_o)
	);

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o
);

	// 100 ns period
	localparam int HALF_PERIOD = 50;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk_o = ~clk_o;
		end
	end

endmodule

//--- testbench/sklansky_add_sub_chk.sv
`timescale 1ns/1ns

module sklansky_add_sub_chk (
	input logic             clk_i,
	input logic             reset_i,
	input adder_pkg::data_t a_i,
	input adder_pkg::data_t b_i,
	input logic             sub_i,
	input adder_pkg::data_t sum_i,
	input logic             overflow_i
);

	localparam int SIGN = adder_pkg::DATA_WIDTH - 1;

	adder_pkg::data_t b_eff;
	adder_pkg::data_t result;
	logic             sign_overflow;

	// Failed assertions so far, read by the testbench top
	int assert_failures = 0;

	assign b_eff  = sub_i ? ~b_i : b_i;
	assign result = sub_i ? a_i - b_i : a_i + b_i;

	// Same-signed operands, result of the other sign
	assign sign_overflow = (a_i[SIGN] == b_eff[SIGN]) && (result[SIGN] != a_i[SIGN]);

	////////////////////////////////////////////////////////////////////////////
	// Port rules
	////////////////////////////////////////////////////////////////////////////

	reset_clears_outputs: assert property (
		@(posedge clk_i) reset_i |=> (sum_i == '0 && !overflow_i)
	) else begin
		assert_failures++;
		$error("Outputs not cleared after a reset edge");
	end

	overflow_follows_sign_rule: assert property (
		@(posedge clk_i) !reset_i |=> (overflow_i == $past(sign_overflow))
	) else begin
		assert_failures++;
		$error("overflow_o disagrees with the sign rule of the previous inputs");
	end

	outputs_known: assert property (
		@(posedge clk_i) !reset_i |=> !$isunknown({sum_i, overflow_i})
	) else begin
		assert_failures++;
		$error("Outputs hold unknown bits after a clock edge");
	end

endmodule

//--- testbench/tb_sklansky_add_sub.sv
`timescale 1ns/1ns

module tb_sklansky_add_sub;

	localparam int GOLDEN_COUNT = 92;
	localparam int FIELDS       = 5;
	localparam int RANDOM_COUNT = 200;
	localparam int RESET_CYCLES = 3;
	localparam int CYCLE_LIMIT  = GOLDEN_COUNT + RANDOM_COUNT + RESET_CYCLES + 20;
	localparam int DRIVE_DELAY  = 5;
	localparam int SIGN         = adder_pkg::DATA_WIDTH - 1;

	logic             clk;
	logic             reset;
	adder_pkg::data_t a;
	adder_pkg::data_t b;
	logic             sub;
	adder_pkg::data_t sum;
	logic             overflow;

	// A, B, sub, sum, overflow for each vector
	adder_pkg::data_t golden_mem [GOLDEN_COUNT*FIELDS];

	// Expected results wait here for one cycle
	adder_pkg::data_t exp_sum_q   [$];
	logic             exp_ovf_q   [$];
	string            vector_name_q [$];

	int          sum_errors    = 0;
	int          ovf_errors    = 0;
	int          assert_errors = 0;
	int          other_errors  = 0;
	int          cycle_count   = 0;
	logic [31:0] rand_state;

	tb_clock_gen i_clock_gen (
		.clk_o (clk)
	);

	sklansky_add_sub i_dut (
		.clk_i      (clk),
		.reset_i    (reset),
		.a_i        (a),
		.b_i        (b),
		.sub_i      (sub),
		.sum_o      (sum),
		.overflow_o (overflow)
	);

	bind sklansky_add_sub sklansky_add_sub_chk i_chk (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.a_i        (a_i),
		.b_i        (b_i),
		.sub_i      (sub_i),
		.sum_i      (sum_o),
		.overflow_i (overflow_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference rules and random source
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Subtraction compares against the inverted B
	function automatic logic expected_overflow(
		input adder_pkg::data_t op_a,
		input adder_pkg::data_t op_b,
		input logic             do_sub,
		input adder_pkg::data_t result
	);
		logic op_b_sign;
		op_b_sign = do_sub ? ~op_b[SIGN] : op_b[SIGN];
		return (op_a[SIGN] == op_b_sign) && (result[SIGN] != op_a[SIGN]);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_sum(
		input adder_pkg::data_t expected,
		input adder_pkg::data_t actual,
		input string            where
	);
		if (actual !== expected) begin
			sum_errors++;
			$display("Fail sum_o expected %h actual %h at %s", expected, actual, where);
		end
	endtask

	task automatic check_overflow(
		input logic  expected,
		input logic  actual,
		input string where
	);
		if (actual !== expected) begin
			ovf_errors++;
			$display("Fail overflow_o expected %h actual %h at %s", expected, actual, where);
		end
	endtask

	task automatic compare_pending();
		adder_pkg::data_t exp_sum;
		logic             exp_ovf;
		string            where;
		if (exp_sum_q.size() > 0) begin
			exp_sum = exp_sum_q.pop_front();
			exp_ovf = exp_ovf_q.pop_front();
			where   = vector_name_q.pop_front();
			check_sum(exp_sum, sum, where);
			check_overflow(exp_ovf, overflow, where);
		end
	endtask

	// Result of the previous vector is checked before the next one goes in
	task automatic apply_vector(
		input adder_pkg::data_t op_a,
		input adder_pkg::data_t op_b,
		input logic             do_sub,
		input adder_pkg::data_t exp_sum,
		input logic             exp_ovf,
		input string            where
	);
		@(posedge clk);
		#DRIVE_DELAY;
		compare_pending();
		a   = op_a;
		b   = op_b;
		sub = do_sub;
		exp_sum_q.push_back(exp_sum);
		exp_ovf_q.push_back(exp_ovf);
		vector_name_q.push_back(where);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		adder_pkg::data_t rand_a;
		adder_pkg::data_t rand_b;
		logic             rand_sub;
		adder_pkg::data_t rand_sum;
		int               base;

		// Operands held through reset would give a nonzero sum and overflow
		reset      = 1'b1;
		a          = 32'h7FFF_FFFF;
		b          = 32'h0000_0001;
		sub        = 1'b0;
		rand_state = 32'hb80d;

		$readmemh("testbench/add_sub_golden.txt", golden_mem);
		if ($isunknown(golden_mem[GOLDEN_COUNT*FIELDS-1])) begin
			other_errors++;
			$display("Golden vector file is missing or holds fewer than %0d vectors",
				GOLDEN_COUNT);
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		check_sum('0, sum, "reset");
		check_overflow(1'b0, overflow, "reset");
		reset = 1'b0;

		for (int i = 0; i < GOLDEN_COUNT; i++) begin
			base = i * FIELDS;
			apply_vector(golden_mem[base], golden_mem[base+1], golden_mem[base+2][0],
				golden_mem[base+3], golden_mem[base+4][0],
				$sformatf("golden vector %0d", i + 1));
		end

		for (int i = 0; i < RANDOM_COUNT; i++) begin
			rand_state = next_random(rand_state);
			rand_a     = rand_state;
			rand_state = next_random(rand_state);
			rand_b     = rand_state;
			rand_state = next_random(rand_state);
			rand_sub   = rand_state[7];
			rand_sum   = rand_sub ? rand_a - rand_b : rand_a + rand_b;
			apply_vector(rand_a, rand_b, rand_sub, rand_sum,
				expected_overflow(rand_a, rand_b, rand_sub, rand_sum),
				$sformatf("random vector %0d", i + 1));
		end

		// Last result comes out one edge later
		@(posedge clk);
		#DRIVE_DELAY;
		compare_pending();

		assert_errors = i_dut.i_chk.assert_failures;

		$display("Errors: sum_o %0d, overflow_o %0d, assertion %0d, other %0d",
			sum_errors, ovf_errors, assert_errors, other_errors);
		if (sum_errors + ovf_errors + assert_errors + other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Run limit
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles before all vectors were checked",
				cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

//--- testbench/add_sub_golden.txt
// A, B, sub, expected sum, expected overflow
// One vector per line in hex
00000000 00000000 0 00000000 0
00000001 00000001 0 00000002 0
0000FFFF 00000001 0 00010000 0
0000FFFF 0000FFFF 0 0001FFFE 0
00008000 00008000 0 00010000 0
7FFFFFFF 00000001 0 80000000 1
7FFFFFFF 7FFFFFFF 0 FFFFFFFE 1
FFFFFFFF 00000001 0 00000000 0
80000000 80000000 0 00000000 1
80000000 FFFFFFFF 0 7FFFFFFF 1
FFFFFFFF FFFFFFFF 0 FFFFFFFE 0
12345678 11111111 0 23456789 0
40000000 40000000 0 80000000 1
3FFFFFFF 40000000 0 7FFFFFFF 0
00FF00FF 00010001 0 01000100 0
0001FFFF 00000001 0 00020000 0
FFFF0000 00010000 0 00000000 0
0000FFFF FFFF0001 0 00000000 0
AAAAAAAA 55555555 0 FFFFFFFF 0
55555555 55555555 0 AAAAAAAA 1
AAAAAAAA AAAAAAAA 0 55555554 1
00000001 FFFFFFFF 0 00000000 0
7FFF8000 00008000 0 80000000 1
0000FFFF 00000000 0 0000FFFF 0
89ABCDEF 01234567 0 8ACF1356 0
0F0F0F0F F0F0F0F0 0 FFFFFFFF 0
0F0F0F0F F0F0F0F1 0 00000000 0
00007FFF 00008001 0 00010000 0
12345678 87654321 0 99999999 0
7FFFFFFF 80000000 0 FFFFFFFF 0
80000001 80000001 0 00000002 1
C0000000 C0000000 0 80000000 0
C0000000 BFFFFFFF 0 7FFFFFFF 1
DEADBEEF 00000000 0 DEADBEEF 0
00000000 CAFEBABE 0 CAFEBABE 0
0000FFFE 00000001 0 0000FFFF 0
FFFEFFFF 00000001 0 FFFF0000 0
FFFFFFFE 00000001 0 FFFFFFFF 0
00010000 0000FFFF 0 0001FFFF 0
1000FFFF 1000FFFF 0 2001FFFE 0
00000000 00000001 1 FFFFFFFF 0
00000005 00000005 1 00000000 0
80000000 00000001 1 7FFFFFFF 1
7FFFFFFF FFFFFFFF 1 80000000 1
00000000 80000000 1 80000000 1
80000000 80000000 1 00000000 0
00010000 00000001 1 0000FFFF 0
00000000 00000000 1 00000000 0
FFFFFFFF FFFFFFFF 1 00000000 0
00000001 00000002 1 FFFFFFFF 0
12345678 12345678 1 00000000 0
23456789 11111111 1 12345678 0
80000000 7FFFFFFF 1 00000001 1
7FFFFFFF 80000000 1 FFFFFFFF 1
FFFFFFFF 00000001 1 FFFFFFFE 0
00000000 FFFFFFFF 1 00000001 0
00020000 00010001 1 0000FFFF 0
40000000 C0000000 1 80000000 1
C0000000 40000001 1 7FFFFFFF 1
C0000000 40000000 1 80000000 0
99999999 12345678 1 87654321 0
0000FFFF 0000FFFF 1 00000000 0
00010000 0000FFFF 1 00000001 0
00000000 00010000 1 FFFF0000 0
8ACF1356 01234567 1 89ABCDEF 0
AAAAAAAA 55555555 1 55555555 1
55555555 AAAAAAAA 1 AAAAAAAB 1
00000064 000000C8 1 FFFFFF9C 0
00000100 00000001 1 000000FF 0
FFFF0000 00000001 1 FFFEFFFF 0
80000001 00000001 1 80000000 0
80000001 00000002 1 7FFFFFFF 1
7FFFFFFE FFFFFFFF 1 7FFFFFFF 0
7FFFFFFE FFFFFFFE 1 80000000 1
DEADBEEF DEADBEEF 1 00000000 0
00000001 80000000 1 80000001 1
FFFFFFFF 80000000 1 7FFFFFFF 0
00008000 00008001 1 FFFFFFFF 0
10000000 00000001 1 0FFFFFFF 0
FFFFFFFF 7FFFFFFF 1 80000000 0
00000003 00000004 0 00000007 0
FFFFFFF0 00000010 0 00000000 0
0000ABCD 00005433 0 00010000 0
00010000 00000000 1 00010000 0
0000FFFF 00000001 1 0000FFFE 0
00001234 00001234 0 00002468 0
3FFFFFFF 3FFFFFFF 0 7FFFFFFE 0
40000000 3FFFFFFF 0 7FFFFFFF 0
80000000 00000000 1 80000000 0
00000000 7FFFFFFF 1 80000001 0
FFFFFFFE FFFFFFFF 1 FFFFFFFF 0
00ABCDEF 00012345 0 00ACF134 0

//--- vlog.f
source/adder_pkg.sv
source/sklansky_half_tree.sv
source/carry_merge_sum.sv
source/sklansky_add_sub.sv
testbench/tb_clock_gen.sv
testbench/sklansky_add_sub_chk.sv
testbench/tb_sklansky_add_sub.sv

//--- Bender.yml
package:
  name: sklansky_add_sub

sources:
  # Design, package first
  - files:
      - source/adder_pkg.sv
      - source/sklansky_half_tree.sv
      - source/carry_merge_sum.sv
      - source/sklansky_add_sub.sv

  # Testbench with bound checker
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sklansky_add_sub_chk.sv
      - testbench/tb_sklansky_add_sub.sv
